/* hw/resp_pkg.sv */
package resp_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------

  // Route mask width, also the upper bound on requestor count
  localparam int ROUTE_W = 8;

  // Tag identifies the original request
  localparam int TAG_W   = 8;

  localparam int DATA_W  = 32;

  // Address layout: tag in the upper byte, route mask in the lower byte
  localparam int ADR_W   = 16;

  // Saturating discard counter
  localparam int DROP_W  = 16;

  // ----------------------------------------
  // Stored response
  // ----------------------------------------

  typedef struct packed {
    logic [ROUTE_W-1:0] route;
    logic [TAG_W-1:0]   tag;
    logic [DATA_W-1:0]  data;
  } resp_payload_t;

endpackage : resp_pkg

/* hw/resp_ingress.sv */
`timescale 1ns/100ps

module resp_ingress import resp_pkg::*; (
  input  logic              ap_clk,
  input  logic              areset_control,
  input  logic              in_cyc,
  input  logic              in_stb,
  input  logic              in_we,
  input  logic [ADR_W-1:0]  in_adr,
  input  logic [DATA_W-1:0] in_dat,
  input  logic              full,
  output logic              in_ack,
  output logic              wr_en,
  output resp_payload_t     wr_data,
  output logic [DROP_W-1:0] drop_count
);

  // ----------------------------------------
  // Request decode
  // ----------------------------------------
  logic               accept;
  logic               is_write;
  logic               route_empty;
  logic [ROUTE_W-1:0] in_route;
  logic [TAG_W-1:0]   in_tag;

  // One transfer per ack pulse, none while the FIFO is full
  assign accept   = in_cyc & in_stb & ~in_ack & ~full;
  assign is_write = accept & in_we;

  // Split the address into tag and route mask
  assign in_tag      = in_adr[ADR_W-1 -: TAG_W];
  assign in_route    = in_adr[ROUTE_W-1:0];
  assign route_empty = (in_route == '0);

  // ----------------------------------------
  // Acknowledge and FIFO push
  // ----------------------------------------

  // Ack and push leave on the same edge
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_ack <= 1'b0;
      wr_en  <= 1'b0;
    end else begin
      in_ack <= accept;
      wr_en  <= is_write & ~route_empty;
    end
  end

  // Payload is only looked at while wr_en is high
  always_ff @(posedge ap_clk) begin
    if (accept) begin
      wr_data.route <= in_route;
      wr_data.tag   <= in_tag;
      wr_data.data  <= in_dat;
    end
  end

  // ----------------------------------------
  // Discard counter
  // ----------------------------------------

  // Unroutable writes are acked but never stored
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      drop_count <= '0;
    end else if (is_write && route_empty) begin
      // Sticks at all ones
      if (drop_count != {DROP_W{1'b1}}) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

endmodule : resp_ingress

/* hw/resp_fifo.sv */
`timescale 1ns/100ps

module resp_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = 16
) (
  input  logic  ap_clk,
  input  logic  areset_control,
  input  logic  wr_en,
  input  item_t wr_data,
  input  logic  rd_en,
  output item_t rd_data,
  output logic  full,
  output logic  empty
);

  // Depth is a power of two, so the pointers wrap on their own
  localparam int AW = $clog2(DEPTH);

  // ----------------------------------------
  // Storage and pointers
  // ----------------------------------------
  item_t        mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic [AW:0]   count_next;

  logic push;
  logic pop;

  // Requests are ignored at the boundaries
  assign push = wr_en & ~full;
  assign pop  = rd_en & ~empty;

  // Head shown straight from memory
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Occupancy
  // ----------------------------------------

  // Push and pop together leave the count alone
  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  // Flags registered from the next count
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      count <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end else begin
      count <= count_next;
      full  <= (count_next == DEPTH[AW:0]);
      empty <= (count_next == '0);
    end
  end

endmodule : resp_fifo

/* hw/resp_multicast_egress.sv */
`timescale 1ns/100ps

module resp_multicast_egress import resp_pkg::*; #(
  parameter int NUM_REQUESTORS = 4
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  resp_payload_t             rd_data,
  input  logic                      empty,
  input  logic [NUM_REQUESTORS-1:0] out_ack,
  output logic                      rd_en,
  output logic [NUM_REQUESTORS-1:0] out_cyc,
  output logic [NUM_REQUESTORS-1:0] out_stb,
  output logic [TAG_W-1:0]          out_tag,
  output logic [DATA_W-1:0]         out_dat
);

  // ----------------------------------------
  // Controller state
  // ----------------------------------------
  typedef enum logic {
    ST_IDLE,
    ST_DELIVER
  } state_t;

  state_t                    state_q;
  logic [NUM_REQUESTORS-1:0] pending_q;
  logic [NUM_REQUESTORS-1:0] head_mask;
  logic                      load;
  logic                      done;

  // Route bits beyond the last requestor are dropped here
  assign head_mask = rd_data.route[NUM_REQUESTORS-1:0];

  // Take a new head whenever idle and the FIFO has one
  assign load = (state_q == ST_IDLE) & ~empty;

  // All ports served, or nothing in range to begin with
  assign done = (state_q == ST_DELIVER) & (pending_q == '0);

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (!empty) begin
            state_q <= ST_DELIVER;
          end
        end
        ST_DELIVER: begin
          if (pending_q == '0) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Pending mask
  // ----------------------------------------

  // Each ack retires its own port only
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pending_q <= '0;
    end else if (load) begin
      pending_q <= head_mask;
    end else begin
      pending_q <= pending_q & ~out_ack;
    end
  end

  // Shared payload, captured with the head
  always_ff @(posedge ap_clk) begin
    if (load) begin
      out_tag <= rd_data.tag;
      out_dat <= rd_data.data;
    end
  end

  // ----------------------------------------
  // Bus outputs
  // ----------------------------------------

  // A port stays in its cycle until it acks
  assign out_cyc = pending_q;
  assign out_stb = pending_q;

  // One-cycle pop once the last port is done
  assign rd_en = done;

endmodule : resp_multicast_egress

/* hw/resp_demux_top.sv */
`timescale 1ns/100ps

module resp_demux_top import resp_pkg::*; #(
  parameter int NUM_REQUESTORS = 4,
  parameter int FIFO_DEPTH     = 16
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic                      in_cyc,
  input  logic                      in_stb,
  input  logic                      in_we,
  input  logic [ADR_W-1:0]          in_adr,
  input  logic [DATA_W-1:0]         in_dat,
  input  logic [NUM_REQUESTORS-1:0] out_ack,
  output logic                      in_ack,
  output logic [DROP_W-1:0]         drop_count,
  output logic [NUM_REQUESTORS-1:0] out_cyc,
  output logic [NUM_REQUESTORS-1:0] out_stb,
  output logic [TAG_W-1:0]          out_tag,
  output logic [DATA_W-1:0]         out_dat
);

  // ----------------------------------------
  // Internal links
  // ----------------------------------------
  logic          wr_en;
  resp_payload_t wr_data;
  logic          full;
  logic          rd_en;
  resp_payload_t rd_data;
  logic          empty;

  resp_ingress ingress_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .in_cyc        (in_cyc),
    .in_stb        (in_stb),
    .in_we         (in_we),
    .in_adr        (in_adr),
    .in_dat        (in_dat),
    .full          (full),
    .in_ack        (in_ack),
    .wr_en         (wr_en),
    .wr_data       (wr_data),
    .drop_count    (drop_count)
  );

  resp_fifo #(
    .item_t(resp_payload_t),
    .DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en         (wr_en),
    .wr_data       (wr_data),
    .rd_en         (rd_en),
    .rd_data       (rd_data),
    .full          (full),
    .empty         (empty)
  );

  resp_multicast_egress #(
    .NUM_REQUESTORS(NUM_REQUESTORS)
  ) egress_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .rd_data       (rd_data),
    .empty         (empty),
    .out_ack       (out_ack),
    .rd_en         (rd_en),
    .out_cyc       (out_cyc),
    .out_stb       (out_stb),
    .out_tag       (out_tag),
    .out_dat       (out_dat)
  );

endmodule : resp_demux_top

/* verification/resp_checker.sv */
`timescale 1ns/100ps

module resp_checker import resp_pkg::*; #(
  parameter int NUM_REQUESTORS = 4
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic                      in_cyc,
  input  logic                      in_stb,
  input  logic                      in_we,
  input  logic [ADR_W-1:0]          in_adr,
  input  logic [DATA_W-1:0]         in_dat,
  input  logic                      in_ack,
  input  logic [DROP_W-1:0]         drop_count,
  input  logic [NUM_REQUESTORS-1:0] out_cyc,
  input  logic [NUM_REQUESTORS-1:0] out_stb,
  input  logic [NUM_REQUESTORS-1:0] out_ack,
  input  logic [TAG_W-1:0]          out_tag,
  input  logic [DATA_W-1:0]         out_dat,
  input  logic                      hold_acks,
  input  logic                      drain_done,
  input  int                        zero_sent,
  output int                        mismatch_errs,
  output int                        unexpected_errs,
  output int                        missing_errs,
  output int                        other_errs,
  output logic                      report_done
);

  // Waiting this long under the hold means the FIFO is full behind a stuck head
  localparam int STALL_CYCLES = 6;

  // Expected deliveries, oldest first, one entry per target port
  int                exp_port [$];
  logic [TAG_W-1:0]  exp_tag  [$];
  logic [DATA_W-1:0] exp_dat  [$];

  logic hold_seen;
  logic stalled;
  int   wait_cycles;

  task automatic check_reset();
    if (in_ack !== 1'b0 || out_cyc !== '0 || out_stb !== '0 || drop_count !== '0) begin
      $display("[FAIL] %0t: outputs not idle in reset, in_ack %b out_cyc %b out_stb %b drop %0d",
               $time, in_ack, out_cyc, out_stb, drop_count);
      other_errs++;
    end
  endtask

  // Route mask in the low byte, tag in the high byte
  task automatic record_input();
    logic [ROUTE_W-1:0] mask;
    mask = in_adr[ROUTE_W-1:0];
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      if (mask[i]) begin
        exp_port.push_back(i);
        exp_tag.push_back(in_adr[ADR_W-1 -: TAG_W]);
        exp_dat.push_back(in_dat);
      end
    end
  endtask

  task automatic check_deliveries();
    int idx;
    if ((out_stb & ~out_cyc) != '0) begin
      $display("Strobe without cycle at %0t on ports %b", $time, out_stb & ~out_cyc);
      other_errs++;
    end
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      if (out_stb[i] && out_ack[i]) begin
        idx = -1;
        for (int k = exp_port.size() - 1; k >= 0; k--) begin
          if (exp_port[k] == i) idx = k;
        end
        if (idx < 0) begin
          $display("Unexpected delivery on port %0d at %0t: tag 0x%h with nothing outstanding",
                   i, $time, out_tag);
          unexpected_errs++;
        end else begin
          if (out_tag !== exp_tag[idx] || out_dat !== exp_dat[idx]) begin
            $display("[FAIL] %0t: port %0d got tag 0x%h data 0x%h, expected tag 0x%h data 0x%h",
                     $time, i, out_tag, out_dat, exp_tag[idx], exp_dat[idx]);
            mismatch_errs++;
          end
          exp_port.delete(idx);
          exp_tag.delete(idx);
          exp_dat.delete(idx);
        end
      end
    end
  endtask

  // ----------------------------------------
  // Back-pressure during the ack hold
  // ----------------------------------------
  task automatic check_backpressure();
    if (hold_acks) begin
      hold_seen = 1'b1;
      if (in_ack && stalled) begin
        $display("Input accepted at %0t after the FIFO had filled during the ack hold", $time);
        other_errs++;
      end
      if (in_cyc && in_stb && !in_ack) wait_cycles++;
      else wait_cycles = 0;
      if (wait_cycles >= STALL_CYCLES) stalled = 1'b1;
    end else if (hold_seen) begin
      if (!stalled) begin
        $display("Input side never stalled while all output acks were held low");
        other_errs++;
      end
      hold_seen = 1'b0;
    end
  endtask

  task automatic final_report();
    for (int k = 0; k < exp_port.size(); k++) begin
      $display("Missing delivery: port %0d never received tag 0x%h data 0x%h",
               exp_port[k], exp_tag[k], exp_dat[k]);
      missing_errs++;
    end
    if (drop_count !== zero_sent[DROP_W-1:0]) begin
      $display("[FAIL] %0t: drop_count %0d, expected %0d", $time, drop_count, zero_sent);
      other_errs++;
    end
  endtask

  initial begin : monitor
    logic rst_prev;
    mismatch_errs   = 0;
    unexpected_errs = 0;
    missing_errs    = 0;
    other_errs      = 0;
    report_done     = 1'b0;
    hold_seen       = 1'b0;
    stalled         = 1'b0;
    wait_cycles     = 0;
    rst_prev        = 1'b0;
    forever begin
      @(posedge ap_clk);
      // Outputs reflect the reset applied on the previous edge
      if (rst_prev) check_reset();
      if (!areset_control && !report_done) begin
        check_deliveries();
        if (in_cyc && in_stb && in_we && in_ack) record_input();
        check_backpressure();
        if (drain_done) begin
          final_report();
          report_done = 1'b1;
        end
      end
      rst_prev = areset_control;
    end
  end

endmodule : resp_checker

/* verification/tb_top.sv */
`timescale 1ns/100ps

module tb_top import resp_pkg::*; ();

  localparam int NUM_REQUESTORS = 4;
  localparam int FIFO_DEPTH     = 16;
  localparam int SEED           = 18525;
  localparam int NUM_PACKETS    = 400;
  localparam int HOLD_CYCLES    = 60;
  localparam int HOLD_START     = 150;
  localparam int DRAIN_IDLE     = 32;
  localparam int HI_SPAN        = (ROUTE_W > NUM_REQUESTORS) ? ROUTE_W - NUM_REQUESTORS : 1;
  localparam int TIMEOUT_CYCLES = NUM_PACKETS * (NUM_REQUESTORS + 8) * 4 + HOLD_CYCLES;
  localparam logic [ROUTE_W-1:0] IN_RANGE = ROUTE_W'((1 << NUM_REQUESTORS) - 1);

  logic                      ap_clk;
  logic                      areset_control;
  logic                      in_cyc;
  logic                      in_stb;
  logic                      in_we;
  logic [ADR_W-1:0]          in_adr;
  logic [DATA_W-1:0]         in_dat;
  logic [NUM_REQUESTORS-1:0] out_ack;
  logic                      in_ack;
  logic [DROP_W-1:0]         drop_count;
  logic [NUM_REQUESTORS-1:0] out_cyc;
  logic [NUM_REQUESTORS-1:0] out_stb;
  logic [TAG_W-1:0]          out_tag;
  logic [DATA_W-1:0]         out_dat;

  logic hold_acks;
  logic drain_done;
  logic report_done;
  int   sent_count;
  int   zero_sent;
  int   cycle_count;
  int   mismatch_errs;
  int   unexpected_errs;
  int   missing_errs;
  int   other_errs;

  resp_demux_top #(
    .NUM_REQUESTORS(NUM_REQUESTORS),
    .FIFO_DEPTH    (FIFO_DEPTH)
  ) dut_i (
    .ap_clk(ap_clk), .areset_control(areset_control),
    .in_cyc(in_cyc), .in_stb(in_stb), .in_we(in_we), .in_adr(in_adr), .in_dat(in_dat),
    .out_ack(out_ack), .in_ack(in_ack), .drop_count(drop_count),
    .out_cyc(out_cyc), .out_stb(out_stb), .out_tag(out_tag), .out_dat(out_dat)
  );

  resp_checker #(
    .NUM_REQUESTORS(NUM_REQUESTORS)
  ) checker_i (
    .ap_clk(ap_clk), .areset_control(areset_control),
    .in_cyc(in_cyc), .in_stb(in_stb), .in_we(in_we), .in_adr(in_adr), .in_dat(in_dat),
    .in_ack(in_ack), .drop_count(drop_count), .out_cyc(out_cyc), .out_stb(out_stb),
    .out_ack(out_ack), .out_tag(out_tag), .out_dat(out_dat), .hold_acks(hold_acks),
    .drain_done(drain_done), .zero_sent(zero_sent), .mismatch_errs(mismatch_errs),
    .unexpected_errs(unexpected_errs), .missing_errs(missing_errs),
    .other_errs(other_errs), .report_done(report_done)
  );

  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  // Called on a falling edge, returns on the falling edge after the acked rising edge
  task automatic send_resp(input logic [TAG_W-1:0] tag, input logic [ROUTE_W-1:0] mask,
                           input logic [DATA_W-1:0] data);
    in_cyc = 1'b1;
    in_stb = 1'b1;
    in_we  = 1'b1;
    in_adr = {tag, mask};
    in_dat = data;
    @(negedge ap_clk);
    while (!in_ack) @(negedge ap_clk);
    // Request held through the edge that completes the transfer
    @(negedge ap_clk);
    in_cyc = 1'b0;
    in_stb = 1'b0;
  endtask

  // sel 0 gives an empty mask, sel 1 adds a stray bit above the last requestor
  function automatic logic [ROUTE_W-1:0] pick_mask(input int sel);
    logic [31:0]        r;
    logic [ROUTE_W-1:0] m;
    int                 pos;
    r = $urandom;
    m = r[ROUTE_W-1:0] & IN_RANGE;
    if (sel == 0) begin
      m = '0;
    end else if (sel == 1 && NUM_REQUESTORS < ROUTE_W) begin
      pos = NUM_REQUESTORS + int'(r[31:24]) % HI_SPAN;
      m = m | (ROUTE_W'(1) << pos);
    end else if (m == '0) begin
      pos = int'(r[23:16]) % NUM_REQUESTORS;
      m = ROUTE_W'(1) << pos;
    end
    return m;
  endfunction

  task automatic print_counts();
    $display("Error counts: %0d mismatched, %0d unexpected, %0d missing, %0d other",
             mismatch_errs, unexpected_errs, missing_errs, other_errs);
  endtask

  // Requestors ack at random while strobed, except during the hold
  initial begin : ack_drive
    logic [31:0] r;
    out_ack = '0;
    forever begin
      @(negedge ap_clk);
      r = $urandom;
      if (hold_acks) out_ack = '0;
      else out_ack = out_stb & r[NUM_REQUESTORS-1:0];
    end
  end

  // Changes on the rising edge so readers on either edge see a settled value
  initial begin : hold_phase
    hold_acks <= 1'b0;
    wait (sent_count >= HOLD_START);
    @(posedge ap_clk);
    hold_acks <= 1'b1;
    repeat (HOLD_CYCLES) @(posedge ap_clk);
    hold_acks <= 1'b0;
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge ap_clk);
      cycle_count++;
    end
    $display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
    print_counts();
    $display("*** FAILED ***");
    $finish;
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main_seq
    logic [31:0]        r;
    logic [ROUTE_W-1:0] mask;
    int                 gap;
    int                 idle;
    void'($urandom(SEED));
    areset_control = 1'b1;
    in_cyc         = 1'b0;
    in_stb         = 1'b0;
    in_we          = 1'b0;
    in_adr         = '0;
    in_dat         = '0;
    drain_done     = 1'b0;
    sent_count     = 0;
    zero_sent      = 0;
    repeat (2) @(posedge ap_clk);
    @(negedge ap_clk);
    areset_control = 1'b0;

    for (int n = 0; n < NUM_PACKETS; n++) begin
      mask = pick_mask(int'($urandom % 10));
      r    = $urandom;
      if (mask == '0) zero_sent++;
      send_resp(r[TAG_W-1:0], mask, $urandom);
      sent_count++;
      // Back to back while acks are held, so the FIFO fills
      gap = hold_acks ? 0 : int'($urandom % 4);
      repeat (gap) @(negedge ap_clk);
    end

    idle = 0;
    while (idle < DRAIN_IDLE) begin
      @(negedge ap_clk);
      if (out_stb == '0) idle++;
      else idle = 0;
    end
    drain_done = 1'b1;
    wait (report_done);

    print_counts();
    if (mismatch_errs + unexpected_errs + missing_errs + other_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_top

/* src.f */
hw/resp_pkg.sv
hw/resp_ingress.sv
hw/resp_fifo.sv
hw/resp_multicast_egress.sv
hw/resp_demux_top.sv
verification/resp_checker.sv
verification/tb_top.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 -Mdir $(OBJ_DIR) --top-module $(TOP)
PASS_MSG  := *** PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
